/* verilog/riscv_params.svh */
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// data and address width
`define RISCV_XLEN 32

// integer register file
`define RISCV_REG_COUNT 32
`define RISCV_REG_AW 5

// first fetch address after reset
`define RISCV_RESET_PC 32'h0000_0000

`endif

/* verilog/riscv_pkg.sv */
`include "riscv_params.svh"

package riscv_pkg;

    // opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LW  = 7'b0000011,
        OP_IMM = 7'b0010011,
        OP_SW  = 7'b0100011,
        OP_R   = 7'b0110011,
        OP_BEQ = 7'b1100011,
        OP_JAL = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_t;

    // write-back value select
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_t;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic [`RISCV_XLEN-1:0] pc;
        logic [`RISCV_XLEN-1:0] instr;
        logic [`RISCV_XLEN-1:0] pc_plus4;
    } fetch_data_t;

    typedef struct packed {
        logic        reg_write;
        result_src_t result_src;
        logic        mem_write;
        logic        jump;
        logic        branch;
        alu_op_t     alu_control;
        logic        alu_src;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`RISCV_XLEN-1:0]   rd1;
        logic [`RISCV_XLEN-1:0]   rd2;
        logic [`RISCV_XLEN-1:0]   pc;
        logic [`RISCV_REG_AW-1:0] rs1;
        logic [`RISCV_REG_AW-1:0] rs2;
        logic [`RISCV_REG_AW-1:0] rd;
        logic [`RISCV_XLEN-1:0]   imm_ext;
        logic [`RISCV_XLEN-1:0]   pc_plus4;
    } decode_data_t;

    typedef struct packed {
        decode_ctrl_t ctrl;
        decode_data_t data;
    } id_ex_t;

    typedef struct packed {
        logic                     reg_write;
        result_src_t              result_src;
        logic                     mem_write;
        logic [`RISCV_XLEN-1:0]   alu_result;
        logic [`RISCV_XLEN-1:0]   write_data;
        logic [`RISCV_REG_AW-1:0] rd;
        logic [`RISCV_XLEN-1:0]   pc_plus4;
    } exec_stage_t;

    typedef struct packed {
        logic                     reg_write;
        result_src_t              result_src;
        logic [`RISCV_XLEN-1:0]   alu_result;
        logic [`RISCV_XLEN-1:0]   read_data;
        logic [`RISCV_REG_AW-1:0] rd;
        logic [`RISCV_XLEN-1:0]   pc_plus4;
    } mem_stage_t;

endpackage

/* verilog/stage_reg.sv */
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // hazard unit never asks to hold and clear the same register
    a_no_stall_flush: assert property (
        @(posedge clk) disable iff (rst) !(stall && flush)
    ) else $error("stage register stalled and flushed in the same cycle");

endmodule

/* verilog/pc_fetch.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module pc_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   pc_src,
    input  logic [`RISCV_XLEN-1:0] pc_target,
    input  logic [`RISCV_XLEN-1:0] instr,
    output logic [`RISCV_XLEN-1:0] pc,
    output riscv_pkg::fetch_data_t fetch
);

    logic [`RISCV_XLEN-1:0] pc_plus4;
    logic [`RISCV_XLEN-1:0] pc_next;

    assign pc_plus4 = pc + 4;

    // taken branch or jump from execute wins
    assign pc_next = pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RISCV_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    assign fetch.pc       = pc;
    assign fetch.instr    = instr;
    assign fetch.pc_plus4 = pc_plus4;

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module instr_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  riscv_pkg::fetch_data_t   fetch,
    input  logic [`RISCV_REG_AW-1:0] rd_w,
    input  logic [`RISCV_XLEN-1:0]   result_w,
    input  logic                     reg_write_w,
    output riscv_pkg::decode_ctrl_t  ctrl,
    output riscv_pkg::decode_data_t  data
);

    logic [`RISCV_XLEN-1:0]   regs [`RISCV_REG_COUNT];
    logic [`RISCV_XLEN-1:0]   ins;
    riscv_pkg::opcode_t       op;
    logic [2:0]               funct3;
    logic [`RISCV_REG_AW-1:0] rs1;
    logic [`RISCV_REG_AW-1:0] rs2;

    assign ins    = fetch.instr;
    assign op     = riscv_pkg::opcode_t'(ins[6:0]);
    assign funct3 = ins[14:12];
    assign rs1    = ins[19:15];
    assign rs2    = ins[24:20];

    // main decoder, unknown encodings stay a no-op
    always_comb begin
        ctrl = '0;
        ctrl.result_src  = riscv_pkg::RES_ALU;
        ctrl.alu_control = riscv_pkg::ALU_ADD;
        case (op)
            riscv_pkg::OP_R: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_control = ins[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
                    3'b010: ctrl.alu_control = riscv_pkg::ALU_SLT;
                    3'b110: ctrl.alu_control = riscv_pkg::ALU_OR;
                    3'b111: ctrl.alu_control = riscv_pkg::ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            riscv_pkg::OP_IMM: begin
                // addi only
                ctrl.reg_write = (funct3 == 3'b000);
                ctrl.alu_src   = 1'b1;
            end
            riscv_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = riscv_pkg::RES_MEM;
                ctrl.alu_src    = 1'b1;
            end
            riscv_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            riscv_pkg::OP_BEQ: begin
                ctrl.branch      = (funct3 == 3'b000);
                ctrl.alu_control = riscv_pkg::ALU_SUB;
            end
            riscv_pkg::OP_JAL: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = riscv_pkg::RES_PC4;
                ctrl.jump       = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // immediate extension by format
    always_comb begin
        case (op)
            riscv_pkg::OP_SW:  data.imm_ext = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            riscv_pkg::OP_BEQ: data.imm_ext = {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                               ins[11:8], 1'b0};
            riscv_pkg::OP_JAL: data.imm_ext = {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                               ins[30:21], 1'b0};
            default:           data.imm_ext = {{20{ins[31]}}, ins[31:20]};
        endcase
    end

    // written on the falling edge so decode sees it in the same cycle
    always_ff @(negedge clk) begin
        if (reg_write_w && rd_w != '0) begin
            regs[rd_w] <= result_w;
        end
    end

    assign data.rd1      = (rs1 == '0) ? '0 : regs[rs1];
    assign data.rd2      = (rs2 == '0) ? '0 : regs[rs2];
    assign data.pc       = fetch.pc;
    assign data.rs1      = rs1;
    assign data.rs2      = rs2;
    assign data.rd       = ins[11:7];
    assign data.pc_plus4 = fetch.pc_plus4;

    a_unsupported_quiet: assert property (
        @(posedge clk) disable iff (rst)
        !(ins[6:0] inside {riscv_pkg::OP_R, riscv_pkg::OP_IMM, riscv_pkg::OP_LW,
                           riscv_pkg::OP_SW, riscv_pkg::OP_BEQ, riscv_pkg::OP_JAL})
        |-> !(ctrl.reg_write || ctrl.mem_write)
    ) else $error("unsupported opcode %b produced a write", ins[6:0]);

endmodule

/* verilog/exec.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module exec (
    input  riscv_pkg::decode_ctrl_t ctrl,
    input  riscv_pkg::decode_data_t data,
    input  riscv_pkg::fwd_sel_t     forward_a,
    input  riscv_pkg::fwd_sel_t     forward_b,
    input  logic [`RISCV_XLEN-1:0]  alu_result_m,
    input  logic [`RISCV_XLEN-1:0]  result_w,
    output riscv_pkg::exec_stage_t  out_stage,
    output logic                    pc_src,
    output logic [`RISCV_XLEN-1:0]  pc_target
);

    logic [`RISCV_XLEN-1:0] src_a;
    logic [`RISCV_XLEN-1:0] reg_b;
    logic [`RISCV_XLEN-1:0] src_b;
    logic [`RISCV_XLEN-1:0] alu_result;
    logic                   zero;

    function automatic logic [`RISCV_XLEN-1:0] pick(
        input riscv_pkg::fwd_sel_t   sel,
        input logic [`RISCV_XLEN-1:0] from_rf
    );
        case (sel)
            riscv_pkg::FWD_MEM: pick = alu_result_m;
            riscv_pkg::FWD_WB:  pick = result_w;
            default:            pick = from_rf;
        endcase
    endfunction

    assign src_a = pick(forward_a, data.rd1);
    assign reg_b = pick(forward_b, data.rd2);
    assign src_b = ctrl.alu_src ? data.imm_ext : reg_b;

    always_comb begin
        case (ctrl.alu_control)
            riscv_pkg::ALU_SUB: alu_result = src_a - src_b;
            riscv_pkg::ALU_AND: alu_result = src_a & src_b;
            riscv_pkg::ALU_OR:  alu_result = src_a | src_b;
            riscv_pkg::ALU_SLT: alu_result = {{(`RISCV_XLEN-1){1'b0}},
                                              $signed(src_a) < $signed(src_b)};
            default:            alu_result = src_a + src_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // beq and jal both target pc plus immediate
    assign pc_target = data.pc + data.imm_ext;
    assign pc_src    = ctrl.jump || (ctrl.branch && zero);

    assign out_stage.reg_write  = ctrl.reg_write;
    assign out_stage.result_src = ctrl.result_src;
    assign out_stage.mem_write  = ctrl.mem_write;
    assign out_stage.alu_result = alu_result;
    assign out_stage.write_data = reg_b;
    assign out_stage.rd         = data.rd;
    assign out_stage.pc_plus4   = data.pc_plus4;

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module hazard_unit (
    input  logic [`RISCV_REG_AW-1:0] rs1_d,
    input  logic [`RISCV_REG_AW-1:0] rs2_d,
    input  logic [`RISCV_REG_AW-1:0] rs1_e,
    input  logic [`RISCV_REG_AW-1:0] rs2_e,
    input  logic [`RISCV_REG_AW-1:0] rd_e,
    input  logic [`RISCV_REG_AW-1:0] rd_m,
    input  logic [`RISCV_REG_AW-1:0] rd_w,
    input  logic                     reg_write_m,
    input  logic                     reg_write_w,
    input  riscv_pkg::result_src_t   result_src_e,
    input  logic                     pc_src,
    output riscv_pkg::fwd_sel_t      forward_a,
    output riscv_pkg::fwd_sel_t      forward_b,
    output logic                     stall_f,
    output logic                     stall_d,
    output logic                     flush_d,
    output logic                     flush_e
);

    logic lw_stall;

    // memory stage is younger, so it wins over write back
    function automatic riscv_pkg::fwd_sel_t fwd(input logic [`RISCV_REG_AW-1:0] rs);
        if (rs != '0 && reg_write_m && rs == rd_m) begin
            fwd = riscv_pkg::FWD_MEM;
        end else if (rs != '0 && reg_write_w && rs == rd_w) begin
            fwd = riscv_pkg::FWD_WB;
        end else begin
            fwd = riscv_pkg::FWD_RF;
        end
    endfunction

    assign forward_a = fwd(rs1_e);
    assign forward_b = fwd(rs2_e);

    // load in execute feeding the instruction in decode
    assign lw_stall = (result_src_e == riscv_pkg::RES_MEM) && (rd_e != '0)
                      && (rs1_d == rd_e || rs2_d == rd_e);

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src;
    assign flush_e = lw_stall || pc_src;

    // a load and a taken branch or jump never sit in execute together
    always_comb begin
        a_stall_no_redirect: assert final (!(stall_d && flush_d))
            else $error("load-use stall and branch flush in the same cycle");
    end

endmodule

/* verilog/riscv_pipeline.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module riscv_pipeline (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RISCV_XLEN-1:0] instr,
    output logic [`RISCV_XLEN-1:0] pc,
    input  logic [`RISCV_XLEN-1:0] read_data,
    output logic                   data_we,
    output logic [`RISCV_XLEN-1:0] data_addr,
    output logic [`RISCV_XLEN-1:0] din
);

    riscv_pkg::fetch_data_t  fetch_f;
    riscv_pkg::fetch_data_t  fetch_d;
    riscv_pkg::decode_ctrl_t ctrl_d;
    riscv_pkg::decode_data_t data_d;
    riscv_pkg::id_ex_t       id_ex_d;
    riscv_pkg::id_ex_t       id_ex_e;
    riscv_pkg::exec_stage_t  exec_e;
    riscv_pkg::exec_stage_t  exec_m;
    riscv_pkg::mem_stage_t   mem_m;
    riscv_pkg::mem_stage_t   mem_w;

    logic                     stall_f;
    logic                     stall_d;
    logic                     flush_d;
    logic                     flush_e;
    riscv_pkg::fwd_sel_t      forward_a;
    riscv_pkg::fwd_sel_t      forward_b;
    logic                     pc_src_e;
    logic [`RISCV_XLEN-1:0]   pc_target_e;
    logic [`RISCV_REG_AW-1:0] rd_w;
    logic [`RISCV_XLEN-1:0]   result_w;
    logic                     reg_write_w;

    pc_fetch i_pc_fetch (
        .clk(clk), .rst(rst), .stall(stall_f),
        .pc_src(pc_src_e), .pc_target(pc_target_e),
        .instr(instr), .pc(pc), .fetch(fetch_f)
    );

    stage_reg #(.payload_t(riscv_pkg::fetch_data_t)) i_if_id (
        .clk(clk), .rst(rst), .stall(stall_d), .flush(flush_d), .d(fetch_f), .q(fetch_d)
    );

    instr_decode i_instr_decode (
        .clk(clk), .rst(rst), .fetch(fetch_d),
        .rd_w(rd_w), .result_w(result_w), .reg_write_w(reg_write_w),
        .ctrl(ctrl_d), .data(data_d)
    );

    assign id_ex_d.ctrl = ctrl_d;
    assign id_ex_d.data = data_d;

    stage_reg #(.payload_t(riscv_pkg::id_ex_t)) i_id_ex (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush_e), .d(id_ex_d), .q(id_ex_e)
    );

    exec i_exec (
        .ctrl(id_ex_e.ctrl), .data(id_ex_e.data),
        .forward_a(forward_a), .forward_b(forward_b),
        .alu_result_m(exec_m.alu_result), .result_w(result_w),
        .out_stage(exec_e), .pc_src(pc_src_e), .pc_target(pc_target_e)
    );

    stage_reg #(.payload_t(riscv_pkg::exec_stage_t)) i_ex_mem (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(exec_e), .q(exec_m)
    );

    // memory access
    assign data_addr = exec_m.alu_result;
    assign din       = exec_m.write_data;
    assign data_we   = exec_m.mem_write;

    assign mem_m.reg_write  = exec_m.reg_write;
    assign mem_m.result_src = exec_m.result_src;
    assign mem_m.alu_result = exec_m.alu_result;
    assign mem_m.read_data  = read_data;
    assign mem_m.rd         = exec_m.rd;
    assign mem_m.pc_plus4   = exec_m.pc_plus4;

    stage_reg #(.payload_t(riscv_pkg::mem_stage_t)) i_mem_wb (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(mem_m), .q(mem_w)
    );

    // write back
    always_comb begin
        case (mem_w.result_src)
            riscv_pkg::RES_MEM: result_w = mem_w.read_data;
            riscv_pkg::RES_PC4: result_w = mem_w.pc_plus4;
            default:            result_w = mem_w.alu_result;
        endcase
    end

    assign rd_w        = mem_w.rd;
    assign reg_write_w = mem_w.reg_write;

    hazard_unit i_hazard_unit (
        .rs1_d(data_d.rs1), .rs2_d(data_d.rs2),
        .rs1_e(id_ex_e.data.rs1), .rs2_e(id_ex_e.data.rs2), .rd_e(id_ex_e.data.rd),
        .rd_m(exec_m.rd), .rd_w(rd_w),
        .reg_write_m(exec_m.reg_write), .reg_write_w(reg_write_w),
        .result_src_e(id_ex_e.ctrl.result_src), .pc_src(pc_src_e),
        .forward_a(forward_a), .forward_b(forward_b),
        .stall_f(stall_f), .stall_d(stall_d), .flush_d(flush_d), .flush_e(flush_e)
    );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* test/riscv_pipeline_tb.sv */
`timescale 1ns/100ps
`include "riscv_params.svh"

module riscv_pipeline_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int STORE_WAIT      = 150;

    logic                   clk;
    logic                   gen_rst;
    logic                   tb_rst = 1'b1;
    logic                   rst;
    logic [`RISCV_XLEN-1:0] instr;
    logic [`RISCV_XLEN-1:0] pc;
    logic [`RISCV_XLEN-1:0] read_data;
    logic [`RISCV_XLEN-1:0] data_addr;
    logic [`RISCV_XLEN-1:0] din;
    logic                   data_we;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] prog_q [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] seen_addr [$];
    logic [31:0] seen_data [$];
    logic [31:0] lfsr = 32'h640a_680a;

    int test_errs     = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int checks_failed = 0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clock_gen (.clk(clk), .rst(gen_rst));

    assign rst = gen_rst || tb_rst;

    riscv_pipeline dut (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .read_data(read_data),
        .data_we(data_we), .data_addr(data_addr), .din(din)
    );

    // both memories answer in the same cycle
    assign instr     = imem[pc[7:2]];
    assign read_data = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[7:2]] <= din;
        end
    end

    // store log, taken where the memory-stage outputs are settled
    always @(negedge clk) begin
        if (!rst && data_we) begin
            seen_addr.push_back(data_addr);
            seen_data.push_back(din);
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'hc0de_0000 ^ (i * 32'h0001_0003);
    endfunction

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got,
                     expected);
            test_errs++;
        end
    endtask

    task automatic fill_memories;
        for (int i = 0; i < 64; i++) begin
            // nop fill, addi x0 with the word index as immediate
            imem[i] = addi_word(5'd0, 5'd0, 12'(i));
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic start_test;
        test_errs = 0;
        prog_q.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        checks_failed += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%-18s %s", name, (test_errs == 0) ? "passed" : "failed");
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic reset_dut;
        @(negedge clk);
        tb_rst = 1'b1;
        fill_memories();
        foreach (prog_q[i]) begin
            imem[i] = prog_q[i];
        end
        repeat (5) @(negedge clk);
        seen_addr.delete();
        seen_data.delete();
        check_value(pc, `RISCV_RESET_PC, "pc during reset");
        check_value(32'(data_we), 32'd0, "data_we during reset");
        tb_rst = 1'b0;
    endtask

    task automatic run_program(input string name);
        int cycles;
        reset_dut();
        cycles = 0;
        while (seen_addr.size() < exp_addr.size() && cycles < STORE_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (seen_addr.size() < exp_addr.size()) begin
            $display("%s: store %0d of %0d never came within %0d cycles", name,
                     seen_addr.size() + 1, exp_addr.size(), STORE_WAIT);
            test_errs++;
        end
        for (int i = 0; i < seen_addr.size() && i < exp_addr.size(); i++) begin
            check_value(seen_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
            check_value(seen_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
        end
        end_test(name);
    endtask

    task automatic reset_and_fetch;
        start_test();
        reset_dut();
        for (int k = 1; k <= 8; k++) begin
            @(negedge clk);
            check_value(pc, `RISCV_RESET_PC + 32'(4 * k), "pc after release");
            check_value(32'(data_we), 32'd0, "data_we with no stores");
        end
        end_test("reset_and_fetch");
    endtask

    task automatic alu_forwarding;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        logic [31:0] x5;
        logic [31:0] x6;
        logic [31:0] x7;
        logic [31:0] x8;
        start_test();
        x1 = sext12(12'd25);
        x2 = sext12(12'hff9);
        x3 = x1 + x2;
        x4 = x3 - x1;
        x5 = x4 & x3;
        x6 = x5 | x2;
        x7 = ($signed(x2) < $signed(x1)) ? 32'd1 : 32'd0;
        x8 = ($signed(x1) < $signed(x4)) ? 32'd1 : 32'd0;
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'd25));
        prog_q.push_back(addi_word(5'd2, 5'd0, 12'hff9));
        prog_q.push_back(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(r_type(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1));
        prog_q.push_back(r_type(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3));
        prog_q.push_back(r_type(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd2));
        prog_q.push_back(r_type(7'b0000000, 3'b010, 5'd7, 5'd2, 5'd1));
        prog_q.push_back(r_type(7'b0000000, 3'b010, 5'd8, 5'd1, 5'd4));
        prog_q.push_back(sw_word(5'd8, 5'd0, 12'd20));
        prog_q.push_back(sw_word(5'd3, 5'd0, 12'd0));
        prog_q.push_back(sw_word(5'd4, 5'd0, 12'd4));
        prog_q.push_back(sw_word(5'd5, 5'd0, 12'd8));
        prog_q.push_back(sw_word(5'd6, 5'd0, 12'd12));
        prog_q.push_back(sw_word(5'd7, 5'd0, 12'd16));
        expect_store(32'd20, x8);
        expect_store(32'd0, x3);
        expect_store(32'd4, x4);
        expect_store(32'd8, x5);
        expect_store(32'd12, x6);
        expect_store(32'd16, x7);
        run_program("alu_forwarding");
    endtask

    task automatic load_use_stall;
        start_test();
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'd8));
        prog_q.push_back(lw_word(5'd2, 5'd1, 12'd0));
        prog_q.push_back(r_type(7'b0000000, 3'b000, 5'd3, 5'd2, 5'd1));
        prog_q.push_back(sw_word(5'd3, 5'd0, 12'd32));
        prog_q.push_back(lw_word(5'd4, 5'd1, 12'd4));
        prog_q.push_back(sw_word(5'd4, 5'd0, 12'd36));
        expect_store(32'd32, fill_word(2) + 32'd8);
        expect_store(32'd36, fill_word(3));
        run_program("load_use_stall");
    endtask

    task automatic branch_flush;
        start_test();
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'd5));
        prog_q.push_back(addi_word(5'd2, 5'd0, 12'd5));
        prog_q.push_back(addi_word(5'd3, 5'd0, 12'd9));
        // taken, lands on the second beq at 24
        prog_q.push_back(beq_word(5'd1, 5'd2, 13'd12));
        prog_q.push_back(sw_word(5'd1, 5'd0, 12'd40));
        prog_q.push_back(sw_word(5'd1, 5'd0, 12'd44));
        prog_q.push_back(beq_word(5'd1, 5'd3, 13'd8));
        prog_q.push_back(sw_word(5'd3, 5'd0, 12'd48));
        prog_q.push_back(sw_word(5'd2, 5'd0, 12'd52));
        expect_store(32'd48, 32'd9);
        expect_store(32'd52, 32'd5);
        run_program("branch_flush");
    endtask

    task automatic jal_link;
        logic [31:0] link;
        start_test();
        // jal sits at address 4
        link = 32'd4 + 32'd4;
        prog_q.push_back(addi_word(5'd1, 5'd0, 12'd3));
        prog_q.push_back(jal_word(5'd5, 21'd12));
        prog_q.push_back(sw_word(5'd1, 5'd0, 12'd56));
        prog_q.push_back(sw_word(5'd1, 5'd0, 12'd60));
        prog_q.push_back(sw_word(5'd5, 5'd0, 12'd64));
        prog_q.push_back(r_type(7'b0000000, 3'b000, 5'd6, 5'd5, 5'd1));
        prog_q.push_back(sw_word(5'd6, 5'd0, 12'd68));
        expect_store(32'd64, link);
        expect_store(32'd68, link + 32'd3);
        run_program("jal_link");
    endtask

    task automatic random_addi_chain;
        logic [31:0] acc;
        logic [31:0] bits;
        logic [11:0] imm;
        logic [11:0] off;
        start_test();
        acc = '0;
        for (int k = 0; k < 8; k++) begin
            draw_bits(12, bits);
            imm = bits[11:0];
            off = 12'(72 + 4 * k);
            prog_q.push_back(addi_word(5'd1, (k == 0) ? 5'd0 : 5'd1, imm));
            prog_q.push_back(sw_word(5'd1, 5'd0, off));
            acc = ((k == 0) ? 32'd0 : acc) + sext12(imm);
            expect_store({20'd0, off}, acc);
        end
        run_program("random_addi_chain");
    endtask

    initial begin
        fill_memories();
        reset_and_fetch();
        alu_forwarding();
        load_use_stall();
        branch_flush();
        jal_link();
        random_addi_chain();
        $display("tests run %0d, tests failed %0d, failed checks %0d", tests_run,
                 tests_failed, checks_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* riscv_pipeline.f */
+incdir+verilog
verilog/riscv_pkg.sv
verilog/stage_reg.sv
verilog/pc_fetch.sv
verilog/instr_decode.sv
verilog/exec.sv
verilog/hazard_unit.sv
verilog/riscv_pipeline.sv
test/clock_gen.sv
test/riscv_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module riscv_pipeline_tb \
    -f riscv_pipeline.f \
    -o riscv_pipeline_sim

./obj_dir/riscv_pipeline_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
